// ==== common/npu_pkg.sv ====
`default_nettype none

package npu_pkg;

  localparam int DATA_W   = 32;
  localparam int STRB_W   = DATA_W / 8;
  localparam int HADDR_W  = 12;
  localparam int BUF_ID_W = 2;
  localparam int OFFS_W   = 8;
  localparam int LINES_W  = 8;
  localparam int STRIDE_W = 2;
  localparam int REG_IDX_W = 3;

  // Buffer ids, code 3 has no buffer behind it
  localparam logic [BUF_ID_W-1:0] BUF_IOB0 = 2'd0;
  localparam logic [BUF_ID_W-1:0] BUF_IOB1 = 2'd1;
  localparam logic [BUF_ID_W-1:0] BUF_WB   = 2'd2;

  // Default depths in address bits
  localparam int AW_IOB0 = 6;
  localparam int AW_IOB1 = 6;
  localparam int AW_WB   = 7;

  // Top two bits of the host address
  localparam logic [1:0] REGION_REG = 2'd0;
  localparam logic [1:0] REGION_BUF = 2'd1;

  localparam logic [REG_IDX_W-1:0] REG_CTRL   = 3'd0; // [0] host owns, [1] start
  localparam logic [REG_IDX_W-1:0] REG_SRC    = 3'd1; // [9:8] id, [7:0] offset
  localparam logic [REG_IDX_W-1:0] REG_DST    = 3'd2;
  localparam logic [REG_IDX_W-1:0] REG_LINES  = 3'd3;
  localparam logic [REG_IDX_W-1:0] REG_STRIDE = 3'd4; // source step is 1 << stride
  localparam logic [REG_IDX_W-1:0] REG_STATUS = 3'd5; // [0] busy, [1] done, [2] error

  typedef struct packed {
    logic               sel;
    logic               wr;
    logic [HADDR_W-1:0] addr;
    logic [DATA_W-1:0]  wdata;
    logic [STRB_W-1:0]  wstrb;
  } host_req_t;

  // Same host address seen by the register block and by the buffer mux
  typedef union packed {
    struct packed {
      logic [1:0]           region;
      logic [6:0]           spare;
      logic [REG_IDX_W-1:0] reg_idx;
    } reg_view;
    struct packed {
      logic [1:0]          region;
      logic [BUF_ID_W-1:0] buf_id;
      logic [OFFS_W-1:0]   offset;
    } buf_view;
  } host_addr_u;

  typedef struct packed {
    logic [BUF_ID_W-1:0] src_id;
    logic [OFFS_W-1:0]   src_off;
    logic [BUF_ID_W-1:0] dst_id;
    logic [OFFS_W-1:0]   dst_off;
    logic [LINES_W-1:0]  lines;
    logic [STRIDE_W-1:0] stride;
  } dma_cfg_t;

  // One access to one bank
  typedef struct packed {
    logic              en;
    logic              we;
    logic [OFFS_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
  } buf_acc_t;

endpackage

`default_nettype wire

// ==== dma/dma_cfg_regs.sv ====
`default_nettype none

module dma_cfg_regs import npu_pkg::*; (
  input  wire               xclk,
  input  wire               i_rst,
  input  host_req_t         i_host,
  input  wire               i_busy,
  input  wire               i_done_pulse,
  input  wire               i_err_pulse,
  output dma_cfg_t          o_cfg,
  output logic              o_start,
  output logic              o_host_own,
  output logic [DATA_W-1:0] o_reg_rdata,
  output logic              o_reg_rvalid
);

  host_addr_u        ha;
  logic              reg_hit;
  logic              reg_wr;
  logic              done;
  logic              err;
  logic [DATA_W-1:0] rd_word;

  assign ha      = i_host.addr;
  assign reg_hit = i_host.sel && (ha.reg_view.region == REGION_REG);
  assign reg_wr  = reg_hit && i_host.wr;

  always_comb begin
    rd_word = '0;
    case (ha.reg_view.reg_idx)
      REG_CTRL:   rd_word[0] = o_host_own; // start bit always reads 0
      REG_SRC:    rd_word[BUF_ID_W+OFFS_W-1:0] = {o_cfg.src_id, o_cfg.src_off};
      REG_DST:    rd_word[BUF_ID_W+OFFS_W-1:0] = {o_cfg.dst_id, o_cfg.dst_off};
      REG_LINES:  rd_word[LINES_W-1:0] = o_cfg.lines;
      REG_STRIDE: rd_word[STRIDE_W-1:0] = o_cfg.stride;
      REG_STATUS: rd_word[2:0] = {err, done, i_busy};
      default:    rd_word = '0;
    endcase
  end

  always_ff @(posedge xclk) begin
    if (i_rst) begin
      o_cfg        <= '0;
      o_host_own   <= 1'b1; // Host holds the buffers out of reset
      o_start      <= 1'b0;
      done         <= 1'b0;
      err          <= 1'b0;
      o_reg_rdata  <= '0;
      o_reg_rvalid <= 1'b0;
    end else begin
      o_start      <= 1'b0;
      o_reg_rvalid <= reg_hit && !i_host.wr;
      o_reg_rdata  <= (reg_hit && !i_host.wr) ? rd_word : '0;

      if (reg_wr) begin
        case (ha.reg_view.reg_idx)
          REG_CTRL: begin
            o_host_own <= i_host.wdata[0];
            // Start only with the buffers handed to the DMA and the engine idle
            o_start    <= i_host.wdata[1] && !i_host.wdata[0] && !i_busy;
          end
          REG_SRC:    {o_cfg.src_id, o_cfg.src_off} <= i_host.wdata[BUF_ID_W+OFFS_W-1:0];
          REG_DST:    {o_cfg.dst_id, o_cfg.dst_off} <= i_host.wdata[BUF_ID_W+OFFS_W-1:0];
          REG_LINES:  o_cfg.lines <= i_host.wdata[LINES_W-1:0];
          REG_STRIDE: o_cfg.stride <= i_host.wdata[STRIDE_W-1:0];
          default: ;
        endcase
      end

      // Sticky flags, write 1 to clear, a new start clears both
      if (i_done_pulse)
        done <= 1'b1;
      else if (o_start || (reg_wr && ha.reg_view.reg_idx == REG_STATUS && i_host.wdata[1]))
        done <= 1'b0;

      if (i_err_pulse)
        err <= 1'b1;
      else if (o_start || (reg_wr && ha.reg_view.reg_idx == REG_STATUS && i_host.wdata[2]))
        err <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== dma/dma_engine.sv ====
`default_nettype none

module dma_engine import npu_pkg::*; #(
  parameter int AW_IOB0 = npu_pkg::AW_IOB0,
  parameter int AW_IOB1 = npu_pkg::AW_IOB1,
  parameter int AW_WB   = npu_pkg::AW_WB
) (
  input  wire                 xclk,
  input  wire                 i_rst,
  input  wire                 i_start,
  input  dma_cfg_t            i_cfg,
  input  wire  [DATA_W-1:0]   i_src_rdata,
  output buf_acc_t            o_rd_acc,
  output buf_acc_t            o_wr_acc,
  output logic [BUF_ID_W-1:0] o_rd_id,
  output logic [BUF_ID_W-1:0] o_wr_id,
  output logic                o_busy,
  output logic                o_done_pulse,
  output logic                o_err_pulse,
  output logic                o_interrupt
);

  logic                busy;
  logic                rd_act;
  logic [LINES_W-1:0]  rd_left;
  logic [OFFS_W-1:0]   rd_off;
  logic                wr_vld;
  logic                wr_last;
  logic [OFFS_W-1:0]   wr_off;
  logic [STRIDE_W-1:0] stride;
  logic [OFFS_W-1:0]   src_step;
  logic                start_ok;
  logic                cfg_bad;
  logic                last_wr;

  // Offset wrap follows the depth of the addressed bank
  function automatic logic [OFFS_W-1:0] wrap_mask(input logic [BUF_ID_W-1:0] id);
    case (id)
      BUF_IOB0: wrap_mask = OFFS_W'((1 << AW_IOB0) - 1);
      BUF_IOB1: wrap_mask = OFFS_W'((1 << AW_IOB1) - 1);
      BUF_WB:   wrap_mask = OFFS_W'((1 << AW_WB) - 1);
      default:  wrap_mask = '0;
    endcase
  endfunction

  assign start_ok = i_start && !busy;
  assign cfg_bad  = (i_cfg.lines == '0) || (i_cfg.src_id == i_cfg.dst_id) ||
                    (i_cfg.src_id == BUF_ID_W'(3)) || (i_cfg.dst_id == BUF_ID_W'(3));
  assign src_step = OFFS_W'(1) << stride;
  assign last_wr  = wr_vld && wr_last;

  always_ff @(posedge xclk) begin
    if (i_rst) begin
      busy         <= 1'b0;
      rd_act       <= 1'b0;
      wr_vld       <= 1'b0;
      wr_last      <= 1'b0;
      o_done_pulse <= 1'b0;
      o_err_pulse  <= 1'b0;
      o_interrupt  <= 1'b0;
    end else begin
      o_done_pulse <= last_wr;
      o_err_pulse  <= start_ok && cfg_bad; // rejected, nothing moves
      o_interrupt  <= last_wr || (start_ok && cfg_bad);
      wr_vld       <= rd_act; // write stage trails read by one cycle
      wr_last      <= rd_act && (rd_left == LINES_W'(1));
      if (start_ok && !cfg_bad) begin
        busy   <= 1'b1;
        rd_act <= 1'b1;
      end else begin
        if (rd_act && rd_left == LINES_W'(1))
          rd_act <= 1'b0;
        if (last_wr)
          busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge xclk) begin
    if (start_ok && !cfg_bad) begin
      o_rd_id <= i_cfg.src_id;
      o_wr_id <= i_cfg.dst_id;
      stride  <= i_cfg.stride;
      rd_left <= i_cfg.lines;
      rd_off  <= i_cfg.src_off & wrap_mask(i_cfg.src_id);
      wr_off  <= i_cfg.dst_off & wrap_mask(i_cfg.dst_id);
    end else begin
      if (rd_act) begin
        rd_off  <= (rd_off + src_step) & wrap_mask(o_rd_id);
        rd_left <= rd_left - LINES_W'(1);
      end
      if (wr_vld)
        wr_off <= (wr_off + OFFS_W'(1)) & wrap_mask(o_wr_id);
    end
  end

  assign o_rd_acc = '{en: rd_act, we: 1'b0, addr: rd_off, wdata: '0, wstrb: '0};
  assign o_wr_acc = '{en: wr_vld, we: wr_vld, addr: wr_off, wdata: i_src_rdata, wstrb: '1};
  assign o_busy   = busy;

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, and pass only on the pass line
cd "$(dirname "$0")" &&
verilator --binary --assert --top-module npu_sys_tb -f src.f -o npu_sys_sim &&
./obj_dir/npu_sys_sim +verilator+error+limit+1000 | tee /dev/stderr |
  grep -x "TEST RESULT: PASS" > /dev/null &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

// ==== src.f ====
common/npu_pkg.sv
verilog/buf_bank.sv
verilog/buf_mux.sv
dma/dma_cfg_regs.sv
dma/dma_engine.sv
verilog/npu_sys.sv
verif/npu_sys_chk.sv
verif/npu_sys_tb.sv

// ==== verif/npu_sys_chk.sv ====
`default_nettype none

module dma_engine_chk import npu_pkg::*; (
  input wire      xclk,
  input wire      i_rst,
  input wire      i_start,
  input wire      i_busy,
  input buf_acc_t i_wr_acc,
  input wire      i_interrupt
);

  int fail_count = 0;

  // Interrupt is a single-cycle pulse
  irq_pulse: assert property (@(posedge xclk) disable iff (i_rst) i_interrupt |=> !i_interrupt)
    else begin
      fail_count++;
      $error("interrupt high for two cycles");
    end

  wr_in_busy: assert property (@(posedge xclk) disable iff (i_rst) i_wr_acc.en |-> i_busy)
    else begin
      fail_count++;
      $error("write access outside a transfer");
    end

  // Register block holds start back while a transfer runs
  start_busy: assert property (@(posedge xclk) disable iff (i_rst) i_start |-> !i_busy)
    else begin
      fail_count++;
      $error("start accepted while busy");
    end

endmodule

bind dma_engine dma_engine_chk u_chk (
  .xclk(xclk), .i_rst(i_rst), .i_start(i_start), .i_busy(o_busy), .i_wr_acc(o_wr_acc),
  .i_interrupt(o_interrupt)
);

`default_nettype wire

// ==== verif/npu_sys_tb.sv ====
`default_nettype none

module npu_sys_tb import npu_pkg::*; ();

  logic              xclk;
  logic              i_rst;
  host_req_t         i_host;
  logic [DATA_W-1:0] o_rdata;
  logic              o_rvalid;
  logic              o_interrupt;

  logic [DATA_W-1:0] mem_model [3][1 << AW_WB]; // Mirrors IOB0, IOB1, WB
  logic [DATA_W-1:0] reg_model [8];
  bit                host_owns;
  int                err_cnt;
  int                chk_cnt;

  npu_sys #(.AW_IOB0(AW_IOB0), .AW_IOB1(AW_IOB1), .AW_WB(AW_WB)) UUT (
    .xclk(xclk), .i_rst(i_rst), .i_host(i_host),
    .o_rdata(o_rdata), .o_rvalid(o_rvalid), .o_interrupt(o_interrupt)
  );

  initial begin
    xclk = 1'b0;
    forever #20 xclk = ~xclk;
  end

  function automatic int depth_of(input int id);
    case (id)
      0:       depth_of = 1 << AW_IOB0;
      1:       depth_of = 1 << AW_IOB1;
      default: depth_of = 1 << AW_WB;
    endcase
  endfunction

  function automatic logic [HADDR_W-1:0] buf_addr(input int id, input int off);
    buf_addr = {REGION_BUF, BUF_ID_W'(id), OFFS_W'(off)};
  endfunction

  function automatic logic [HADDR_W-1:0] reg_addr(input logic [REG_IDX_W-1:0] idx);
    reg_addr = {REGION_REG, 7'd0, idx};
  endfunction

  // Readable bits of each config register
  function automatic logic [DATA_W-1:0] reg_mask(input logic [REG_IDX_W-1:0] idx);
    case (idx)
      REG_SRC, REG_DST: reg_mask = 32'h3ff;
      REG_LINES:        reg_mask = 32'hff;
      REG_STRIDE:       reg_mask = 32'h3;
      default:          reg_mask = 32'h0;
    endcase
  endfunction

  task automatic compare(input string name, input logic [DATA_W-1:0] exp,
                         input logic [DATA_W-1:0] act);
    chk_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("ERR %s: expected %08h, actual %08h", name, exp, act);
    end
  endtask

  task automatic host_write(input logic [HADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                            input logic [STRB_W-1:0] wstrb);
    @(posedge xclk);
    i_host <= '{sel: 1'b1, wr: 1'b1, addr: addr, wdata: wdata, wstrb: wstrb};
    @(posedge xclk);
    i_host <= '0; // Write lands on this edge
  endtask

  task automatic host_read(input logic [HADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
    @(posedge xclk);
    i_host <= '{sel: 1'b1, wr: 1'b0, addr: addr, wdata: '0, wstrb: '0};
    @(posedge xclk);
    i_host <= '0;
    @(negedge xclk); // Response due exactly one cycle after the request
    if (o_rvalid !== 1'b1) begin
      err_cnt++;
      $display("Read at address %03h got no valid response one cycle later", addr);
    end
    data = o_rdata;
  endtask

  task automatic write_buf(input int id, input int off, input logic [DATA_W-1:0] wdata,
                           input logic [STRB_W-1:0] wstrb);
    host_write(buf_addr(id, off), wdata, wstrb);
    if (host_owns) begin
      for (int b = 0; b < STRB_W; b++)
        if (wstrb[b])
          mem_model[id][off][b*8 +: 8] = wdata[b*8 +: 8];
    end
  endtask

  task automatic verify_bufs(input string name);
    logic [DATA_W-1:0] rd;
    for (int id = 0; id < 3; id++)
      for (int off = 0; off < depth_of(id); off++) begin
        host_read(buf_addr(id, off), rd);
        compare($sformatf("%s buf%0d[%0d]", name, id, off), mem_model[id][off], rd);
      end
  endtask

  task automatic set_ctrl(input bit own, input bit start);
    host_write(reg_addr(REG_CTRL), {30'd0, start, own}, 4'hf);
    host_owns = own;
  endtask

  task automatic program_cfg(input int src, input int soff, input int dst, input int doff,
                             input int lines, input int stride);
    reg_model[REG_SRC]    = {22'd0, BUF_ID_W'(src), OFFS_W'(soff)};
    reg_model[REG_DST]    = {22'd0, BUF_ID_W'(dst), OFFS_W'(doff)};
    reg_model[REG_LINES]  = {24'd0, LINES_W'(lines)};
    reg_model[REG_STRIDE] = {30'd0, STRIDE_W'(stride)};
    for (int r = REG_SRC; r <= REG_STRIDE; r++)
      host_write(reg_addr(REG_IDX_W'(r)), reg_model[r], 4'hf);
  endtask

  // Counts cycles from the CTRL write edge until the interrupt or the limit
  task automatic wait_irq(input int limit, output bit got, output int cyc, output int scyc);
    got  = 1'b0;
    cyc  = 0;
    scyc = 0;
    while (cyc < limit && !got) begin
      @(negedge xclk);
      cyc++;
      if (UUT.start && scyc == 0)
        scyc = cyc;
      got = o_interrupt;
    end
  endtask

  task automatic run_copy();
    int src, dst, lines, stride, soff, doff, cyc, scyc;
    bit got;
    logic [DATA_W-1:0] rd;
    src    = $urandom_range(2, 0);
    dst    = (src + $urandom_range(2, 1)) % 3;
    lines  = $urandom_range(80, 1);
    stride = $urandom_range(3, 0);
    soff   = $urandom_range(255, 0);
    doff   = $urandom_range(255, 0);
    program_cfg(src, soff, dst, doff, lines, stride);
    set_ctrl(1'b0, 1'b1);
    wait_irq(lines + 20, got, cyc, scyc);
    if (!got) begin
      err_cnt++;
      $display("DMA copy of %0d lines gave no interrupt before the timeout", lines);
    end else begin
      compare("dma start delay", 32'd1, 32'(scyc));
      compare("dma irq latency", 32'(lines + 2), 32'(cyc - scyc));
    end
    // Source steps by the stride and destination by one, both within the bank depth
    for (int i = 0; i < lines; i++)
      mem_model[dst][(doff + i) & (depth_of(dst) - 1)] =
        mem_model[src][(soff + (i << stride)) & (depth_of(src) - 1)];
    set_ctrl(1'b1, 1'b0);
    host_read(reg_addr(REG_STATUS), rd);
    compare("dma status", 32'h2, rd);
    verify_bufs("dma copy");
  endtask

  // A second start written during a transfer leaves the transfer untouched
  task automatic restart_while_busy();
    int cyc, scyc;
    bit got;
    logic [DATA_W-1:0] rd;
    program_cfg(0, 0, 2, 0, 40, 1);
    set_ctrl(1'b0, 1'b1);
    set_ctrl(1'b0, 1'b1); // Engine is busy by now
    wait_irq(60, got, cyc, scyc);
    if (!got) begin
      err_cnt++;
      $display("Copy with a repeated start gave no interrupt before the timeout");
    end else begin
      compare("restart irq latency", 32'd41, 32'(cyc)); // lines + 1 from the second write
    end
    for (int i = 0; i < 40; i++)
      mem_model[2][i] = mem_model[0][(i << 1) & (depth_of(0) - 1)];
    set_ctrl(1'b1, 1'b0);
    host_read(reg_addr(REG_STATUS), rd);
    compare("restart status", 32'h2, rd);
  endtask

  task automatic run_reject(input int kind);
    int src, dst, lines, cyc, scyc;
    bit got;
    logic [DATA_W-1:0] rd;
    src   = $urandom_range(2, 0);
    dst   = (src + 1) % 3;
    lines = $urandom_range(20, 1);
    case (kind)
      0:       dst = src;
      1:       src = 3;
      2:       dst = 3;
      default: lines = 0;
    endcase
    program_cfg(src, $urandom_range(255, 0), dst, $urandom_range(255, 0), lines,
                $urandom_range(3, 0));
    set_ctrl(1'b0, 1'b1);
    wait_irq(20, got, cyc, scyc);
    if (!got) begin
      err_cnt++;
      $display("Rejected config %0d gave no interrupt before the timeout", kind);
    end else begin
      compare("reject irq delay", 32'd2, 32'(cyc));
    end
    set_ctrl(1'b1, 1'b0);
    host_read(reg_addr(REG_STATUS), rd);
    compare("reject status", 32'h4, rd);
    host_write(reg_addr(REG_STATUS), 32'h4, 4'hf); // Clear error
    host_read(reg_addr(REG_STATUS), rd);
    compare("status clear", 32'h0, rd);
  endtask

  initial begin
    logic [DATA_W-1:0]    rd;
    logic [DATA_W-1:0]    wdata;
    logic [REG_IDX_W-1:0] idx;
    int id, off, cyc, scyc;
    bit got;
    void'($urandom(38));
    err_cnt   = 0;
    chk_cnt   = 0;
    host_owns = 1'b1;
    i_rst  <= 1'b1;
    i_host <= '0;
    repeat (3) @(posedge xclk);
    i_rst <= 1'b0;

    host_read(reg_addr(REG_STATUS), rd);
    compare("reset status", 32'h0, rd);
    host_read(reg_addr(REG_CTRL), rd);
    compare("reset ctrl", 32'h1, rd);
    repeat (12) begin
      idx   = REG_IDX_W'($urandom_range(4, 1)); // SRC through STRIDE
      wdata = $urandom;
      host_write(reg_addr(idx), wdata, 4'hf);
      host_read(reg_addr(idx), rd);
      compare("reg readback", wdata & reg_mask(idx), rd);
    end

    // Full fill first so no bank word stays unknown
    for (id = 0; id < 3; id++)
      for (off = 0; off < depth_of(id); off++)
        write_buf(id, off, $urandom, 4'hf);
    repeat (120) begin
      id  = $urandom_range(2, 0);
      off = $urandom_range(depth_of(id) - 1, 0);
      write_buf(id, off, $urandom, STRB_W'($urandom));
    end
    verify_bufs("host access");

    repeat (6) run_copy();
    restart_while_busy();
    for (int k = 0; k < 4; k++)
      run_reject(k);
    verify_bufs("reject contents");

    set_ctrl(1'b0, 1'b0);
    repeat (16) begin
      id  = $urandom_range(2, 0);
      off = $urandom_range(depth_of(id) - 1, 0);
      write_buf(id, off, $urandom, 4'hf); // Dropped while DMA owns
      host_read(buf_addr(id, off), rd);
      compare("guarded read", 32'h0, rd);
    end
    set_ctrl(1'b1, 1'b0);
    verify_bufs("guarded contents");
    host_write(reg_addr(REG_STATUS), 32'h6, 4'hf);
    program_cfg(0, 0, 1, 0, 4, 0);
    set_ctrl(1'b1, 1'b1);
    wait_irq(30, got, cyc, scyc);
    if (got) begin
      err_cnt++;
      $display("Start while the host owns the buffers raised an interrupt");
    end
    host_read(reg_addr(REG_STATUS), rd);
    compare("owned start status", 32'h0, rd);

    $display("Checks: %0d  errors: %0d  assertion failures: %0d", chk_cnt, err_cnt,
             UUT.u_dma.u_chk.fail_count);
    if (err_cnt == 0 && UUT.u_dma.u_chk.fail_count == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/buf_bank.sv ====
`default_nettype none

module buf_bank import npu_pkg::*; #(
  parameter int ADDR_W = 6
) (
  input  wire               xclk,
  input  buf_acc_t          i_acc,
  output logic [DATA_W-1:0] o_rdata
);

  localparam int DEPTH = 1 << ADDR_W;

  logic [DATA_W-1:0] mem [DEPTH];
  logic [ADDR_W-1:0] addr;

  // Upper offset bits beyond the bank depth are ignored
  assign addr = i_acc.addr[ADDR_W-1:0];

  always_ff @(posedge xclk) begin
    if (i_acc.en && i_acc.we) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (i_acc.wstrb[b])
          mem[addr][b*8 +: 8] <= i_acc.wdata[b*8 +: 8];
      end
    end
  end

  // Registered read, output holds between reads
  always_ff @(posedge xclk) begin
    if (i_acc.en && !i_acc.we)
      o_rdata <= mem[addr];
  end

endmodule

`default_nettype wire

// ==== verilog/buf_mux.sv ====
`default_nettype none

module buf_mux import npu_pkg::*; (
  input  wire                 xclk,
  input  wire                 i_rst,
  input  host_req_t           i_host,
  input  wire                 i_host_own,
  input  buf_acc_t            i_rd_acc,
  input  buf_acc_t            i_wr_acc,
  input  wire  [BUF_ID_W-1:0] i_rd_id,
  input  wire  [BUF_ID_W-1:0] i_wr_id,
  input  wire  [DATA_W-1:0]   i_rdata_iob0,
  input  wire  [DATA_W-1:0]   i_rdata_iob1,
  input  wire  [DATA_W-1:0]   i_rdata_wb,
  output buf_acc_t            o_acc_iob0,
  output buf_acc_t            o_acc_iob1,
  output buf_acc_t            o_acc_wb,
  output logic [DATA_W-1:0]   o_src_rdata,
  output logic [DATA_W-1:0]   o_buf_rdata,
  output logic                o_buf_rvalid
);

  host_addr_u          ha;
  logic                host_hit;
  buf_acc_t            host_acc;
  logic                host_rd_q;
  logic [BUF_ID_W-1:0] host_id_q;
  logic [BUF_ID_W-1:0] src_id_q;

  assign ha       = i_host.addr;
  assign host_hit = i_host.sel && (ha.buf_view.region == REGION_BUF);
  assign host_acc = '{en: host_hit, we: i_host.wr, addr: ha.buf_view.offset,
                      wdata: i_host.wdata, wstrb: i_host.wstrb};

  // Ownership picks the master, src and dst ids never collide on the DMA side
  function automatic buf_acc_t pick(input logic [BUF_ID_W-1:0] id);
    pick = '0;
    if (i_host_own) begin
      if (host_hit && ha.buf_view.buf_id == id)
        pick = host_acc;
    end else if (i_rd_acc.en && i_rd_id == id) begin
      pick = i_rd_acc;
    end else if (i_wr_acc.en && i_wr_id == id) begin
      pick = i_wr_acc;
    end
  endfunction

  function automatic logic [DATA_W-1:0] bank_rdata(input logic [BUF_ID_W-1:0] id);
    case (id)
      BUF_IOB0: bank_rdata = i_rdata_iob0;
      BUF_IOB1: bank_rdata = i_rdata_iob1;
      BUF_WB:   bank_rdata = i_rdata_wb;
      default:  bank_rdata = '0;
    endcase
  endfunction

  always_comb begin
    o_acc_iob0 = pick(BUF_IOB0);
    o_acc_iob1 = pick(BUF_IOB1);
    o_acc_wb   = pick(BUF_WB);
  end

  always_ff @(posedge xclk) begin
    if (i_rst) begin
      host_rd_q    <= 1'b0;
      o_buf_rvalid <= 1'b0;
    end else begin
      host_rd_q    <= host_hit && !i_host.wr && i_host_own;
      o_buf_rvalid <= host_hit && !i_host.wr; // answered with 0 while DMA owns
    end
  end

  always_ff @(posedge xclk) begin
    host_id_q <= ha.buf_view.buf_id;
    src_id_q  <= i_rd_id;
  end

  always_comb begin
    o_buf_rdata = host_rd_q ? bank_rdata(host_id_q) : '0;
    o_src_rdata = bank_rdata(src_id_q);
  end

endmodule

`default_nettype wire

// ==== verilog/npu_sys.sv ====
`default_nettype none

module npu_sys import npu_pkg::*; #(
  parameter int AW_IOB0 = npu_pkg::AW_IOB0,
  parameter int AW_IOB1 = npu_pkg::AW_IOB1,
  parameter int AW_WB   = npu_pkg::AW_WB
) (
  input  wire              xclk,
  input  wire              i_rst,
  input  host_req_t        i_host,
  output logic [DATA_W-1:0] o_rdata,
  output logic             o_rvalid,
  output logic             o_interrupt
);

  dma_cfg_t            cfg;
  logic                start;
  logic                host_own;
  logic                busy;
  logic                done_pulse;
  logic                err_pulse;
  logic [DATA_W-1:0]   reg_rdata;
  logic                reg_rvalid;
  logic [DATA_W-1:0]   buf_rdata;
  logic                buf_rvalid;
  buf_acc_t            rd_acc;
  buf_acc_t            wr_acc;
  logic [BUF_ID_W-1:0] rd_id;
  logic [BUF_ID_W-1:0] wr_id;
  logic [DATA_W-1:0]   src_rdata;
  buf_acc_t            acc_iob0;
  buf_acc_t            acc_iob1;
  buf_acc_t            acc_wb;
  logic [DATA_W-1:0]   rdata_iob0;
  logic [DATA_W-1:0]   rdata_iob1;
  logic [DATA_W-1:0]   rdata_wb;

  dma_cfg_regs u_regs (
    .xclk(xclk), .i_rst(i_rst), .i_host(i_host),
    .i_busy(busy), .i_done_pulse(done_pulse), .i_err_pulse(err_pulse),
    .o_cfg(cfg), .o_start(start), .o_host_own(host_own),
    .o_reg_rdata(reg_rdata), .o_reg_rvalid(reg_rvalid)
  );

  dma_engine #(.AW_IOB0(AW_IOB0), .AW_IOB1(AW_IOB1), .AW_WB(AW_WB)) u_dma (
    .xclk(xclk), .i_rst(i_rst), .i_start(start), .i_cfg(cfg), .i_src_rdata(src_rdata),
    .o_rd_acc(rd_acc), .o_wr_acc(wr_acc), .o_rd_id(rd_id), .o_wr_id(wr_id),
    .o_busy(busy), .o_done_pulse(done_pulse), .o_err_pulse(err_pulse),
    .o_interrupt(o_interrupt)
  );

  buf_mux u_mux (
    .xclk(xclk), .i_rst(i_rst), .i_host(i_host), .i_host_own(host_own),
    .i_rd_acc(rd_acc), .i_wr_acc(wr_acc), .i_rd_id(rd_id), .i_wr_id(wr_id),
    .i_rdata_iob0(rdata_iob0), .i_rdata_iob1(rdata_iob1), .i_rdata_wb(rdata_wb),
    .o_acc_iob0(acc_iob0), .o_acc_iob1(acc_iob1), .o_acc_wb(acc_wb),
    .o_src_rdata(src_rdata), .o_buf_rdata(buf_rdata), .o_buf_rvalid(buf_rvalid)
  );

  buf_bank #(.ADDR_W(AW_IOB0)) u_iob0 (.xclk(xclk), .i_acc(acc_iob0), .o_rdata(rdata_iob0));
  buf_bank #(.ADDR_W(AW_IOB1)) u_iob1 (.xclk(xclk), .i_acc(acc_iob1), .o_rdata(rdata_iob1));
  buf_bank #(.ADDR_W(AW_WB))   u_wb   (.xclk(xclk), .i_acc(acc_wb), .o_rdata(rdata_wb));

  // Both sides drive zero when not answering
  assign o_rdata  = reg_rdata | buf_rdata;
  assign o_rvalid = reg_rvalid | buf_rvalid;

endmodule

`default_nettype wire
